//--- rtl/md_pkg.sv
// ##########################################################################
// Shared definitions of the RV32M multiply/divide unit
// Operation encoding and datapath width constants
// ##########################################################################

`default_nettype none

package md_pkg;

  // Operation requested from the multiply/divide unit
  typedef enum logic [1:0] {
    MD_OP_MULL,
    MD_OP_MULH,
    MD_OP_DIV,
    MD_OP_REM
  } md_op_e;

  // Operand and result width
  localparam int unsigned MD_WIDTH     = 32;
  // Width of one multiplier slice
  localparam int unsigned MD_HALF      = 16;
  // Accumulator and remainder width, two guard bits for the signed sum
  localparam int unsigned MD_ACC_WIDTH = 34;
  // Division step counter
  localparam int unsigned MD_CNT_WIDTH = 5;
  localparam int unsigned MD_DIV_LAST  = 31;

endpackage

`default_nettype wire

//--- rtl/md_mult_fast.sv
// ##########################################################################
// Multi-cycle multiplier built on one 17x17 multiply-accumulate kernel
// MUL takes three cycles, MULH/MULHSU/MULHU take four
// ##########################################################################

`default_nettype none

module md_mult_fast (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           en_i,
  input  logic                           ready_i,
  input  md_pkg::md_op_e                 operator_i,
  input  logic [1:0]                     signed_mode_i,
  input  logic [md_pkg::MD_WIDTH-1:0]    op_a_i,
  input  logic [md_pkg::MD_WIDTH-1:0]    op_b_i,
  output logic [md_pkg::MD_WIDTH-1:0]    result_o,
  output logic                           valid_o
);

  localparam int unsigned W = md_pkg::MD_WIDTH;
  localparam int unsigned H = md_pkg::MD_HALF;
  localparam int unsigned A = md_pkg::MD_ACC_WIDTH;

  typedef enum logic [1:0] {
    ALBL,
    ALBH,
    AHBL,
    AHBH
  } mult_state_e;

  mult_state_e state_q, state_d;

  logic [H-1:0]        mult_op_a;
  logic [H-1:0]        mult_op_b;
  logic                sign_a;
  logic                sign_b;
  logic [A-1:0]        accum;
  logic signed [A-1:0] mac_res;
  logic [A-1:0]        mac_res_d;
  logic [A-1:0]        acc_q;
  logic                signed_mult;
  logic                hold;
  logic                step_en;

  assign signed_mult = (signed_mode_i != 2'b00);

  // Both guard bits of the kernel output carry the same value, so 34 bits suffice
  assign mac_res = $signed({sign_a, mult_op_a}) * $signed({sign_b, mult_op_b}) + $signed(accum);

  always_comb begin
    mult_op_a = op_a_i[H-1:0];
    mult_op_b = op_b_i[H-1:0];
    sign_a    = 1'b0;
    sign_b    = 1'b0;
    accum     = '0;
    mac_res_d = mac_res;
    state_d   = state_q;
    valid_o   = 1'b0;
    hold      = 1'b0;

    unique case (state_q)
      ALBL: begin
        // al*bl, always unsigned
        state_d = ALBH;
      end

      ALBH: begin
        // al*bh, shifted down by one slice
        mult_op_b = op_b_i[W-1:H];
        sign_b    = signed_mode_i[1] & op_b_i[W-1];
        accum     = {{(A-H){1'b0}}, acc_q[W-1:H]};
        if (operator_i == md_pkg::MD_OP_MULL) begin
          // Keep the low product half below the new partial sum
          mac_res_d = {2'b00, mac_res[H-1:0], acc_q[H-1:0]};
        end
        state_d = AHBL;
      end

      AHBL: begin
        // ah*bl
        mult_op_a = op_a_i[W-1:H];
        sign_a    = signed_mode_i[0] & op_a_i[W-1];
        if (operator_i == md_pkg::MD_OP_MULL) begin
          accum     = {{(A-H){1'b0}}, acc_q[W-1:H]};
          mac_res_d = {2'b00, mac_res[H-1:0], acc_q[H-1:0]};
          valid_o   = 1'b1;
          hold      = ~ready_i;
          state_d   = ALBL;
        end else begin
          accum   = acc_q;
          state_d = AHBH;
        end
      end

      AHBH: begin
        // ah*bh on top of the middle sum shifted down by one slice
        mult_op_a = op_a_i[W-1:H];
        mult_op_b = op_b_i[W-1:H];
        sign_a    = signed_mode_i[0] & op_a_i[W-1];
        sign_b    = signed_mode_i[1] & op_b_i[W-1];
        accum     = {{H{signed_mult & acc_q[A-1]}}, acc_q[A-1:H]};
        valid_o   = 1'b1;
        hold      = ~ready_i;
        state_d   = ALBL;
      end

      default: begin
        state_d = ALBL;
      end
    endcase
  end

  // Nothing moves while a finished result waits for the consumer
  assign step_en = en_i & ~hold;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ALBL;
    end else if (step_en) begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (step_en) begin
      acc_q <= mac_res_d;
    end
  end

  assign result_o = mac_res_d[W-1:0];

endmodule

`default_nettype wire

//--- rtl/md_div_long.sv
// ##########################################################################
// Restoring long divider for DIV/DIVU/REM/REMU
// Absolute value, 32 compare-and-subtract steps, then sign fix
// ##########################################################################

`default_nettype none

module md_div_long (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           en_i,
  input  logic                           ready_i,
  input  md_pkg::md_op_e                 operator_i,
  input  logic [1:0]                     signed_mode_i,
  input  logic [md_pkg::MD_WIDTH-1:0]    op_a_i,
  input  logic [md_pkg::MD_WIDTH-1:0]    op_b_i,
  output logic [md_pkg::MD_WIDTH-1:0]    result_o,
  output logic                           valid_o
);

  localparam int unsigned W = md_pkg::MD_WIDTH;
  localparam int unsigned A = md_pkg::MD_ACC_WIDTH;
  localparam int unsigned C = md_pkg::MD_CNT_WIDTH;

  typedef enum logic [2:0] {
    IDLE,
    ABS_A,
    ABS_B,
    COMP,
    LAST,
    CHANGE_SIGN,
    FINISH
  } div_state_e;

  div_state_e state_q, state_d;

  logic [W-1:0] numerator_q, numerator_d;
  logic [W-1:0] denominator_q, denominator_d;
  logic [W-1:0] quotient_q, quotient_d;
  logic [A-1:0] remainder_q, remainder_d;
  logic [C-1:0] cnt_q, cnt_d;

  // Subtractor shared by the abs, compare and negate steps
  logic [W:0]   sub_a;
  logic [W:0]   sub_b;
  logic [W+1:0] sub_ext;
  logic [W-1:0] sub_res;
  logic         sub_borrow;

  logic         sign_a;
  logic         sign_b;
  logic         b_zero;
  logic         div_change_sign;
  logic         rem_change_sign;
  logic         is_greater_equal;
  logic [W-1:0] one_shift;
  logic [W-1:0] next_remainder;
  logic [W-1:0] next_quotient;
  logic         hold;
  logic         step_en;

  assign sub_ext    = {1'b0, sub_a} - {1'b0, sub_b};
  assign sub_res    = sub_ext[W-1:0];
  assign sub_borrow = sub_ext[W+1];

  assign sign_a = signed_mode_i[0] & op_a_i[W-1];
  assign sign_b = signed_mode_i[1] & op_b_i[W-1];
  assign b_zero = (op_b_i == '0);

  assign div_change_sign = (sign_a ^ sign_b) & ~b_zero;
  assign rem_change_sign = sign_a;

  // Partial remainder with the next numerator bit against the divisor
  assign is_greater_equal = ~sub_borrow;
  assign next_remainder   = is_greater_equal ? sub_res : remainder_q[W-1:0];
  assign one_shift        = {{(W-1){1'b0}}, 1'b1} << cnt_q;
  assign next_quotient    = is_greater_equal ? (quotient_q | one_shift) : quotient_q;

  always_comb begin
    state_d       = state_q;
    numerator_d   = numerator_q;
    denominator_d = denominator_q;
    quotient_d    = quotient_q;
    remainder_d   = remainder_q;
    cnt_d         = cnt_q - 1'b1;
    sub_a         = '0;
    sub_b         = {1'b0, op_b_i};
    valid_o       = 1'b0;
    hold          = 1'b0;

    unique case (state_q)
      IDLE: begin
        // RV32M results for a zero divisor
        if (operator_i == md_pkg::MD_OP_DIV) begin
          remainder_d = {2'b00, {W{1'b1}}};
        end else begin
          remainder_d = {2'b00, op_a_i};
        end
        state_d = b_zero ? FINISH : ABS_A;
        cnt_d   = C'(md_pkg::MD_DIV_LAST);
      end

      ABS_A: begin
        sub_b       = {1'b0, op_a_i};
        quotient_d  = '0;
        numerator_d = sign_a ? sub_res : op_a_i;
        cnt_d       = C'(md_pkg::MD_DIV_LAST);
        state_d     = ABS_B;
      end

      ABS_B: begin
        sub_b         = {1'b0, op_b_i};
        remainder_d   = {{(A-1){1'b0}}, numerator_q[W-1]};
        denominator_d = sign_b ? sub_res : op_b_i;
        cnt_d         = C'(md_pkg::MD_DIV_LAST);
        state_d       = COMP;
      end

      COMP: begin
        sub_a       = remainder_q[W:0];
        sub_b       = {1'b0, denominator_q};
        remainder_d = {1'b0, next_remainder, numerator_q[cnt_d]};
        quotient_d  = next_quotient;
        state_d     = (cnt_q == C'(1)) ? LAST : COMP;
      end

      LAST: begin
        // Final step, keep only the value that is asked for
        sub_a      = remainder_q[W:0];
        sub_b      = {1'b0, denominator_q};
        quotient_d = next_quotient;
        if (operator_i == md_pkg::MD_OP_DIV) begin
          remainder_d = {2'b00, next_quotient};
        end else begin
          remainder_d = {2'b00, next_remainder};
        end
        state_d = CHANGE_SIGN;
      end

      CHANGE_SIGN: begin
        sub_b = {1'b0, remainder_q[W-1:0]};
        if (operator_i == md_pkg::MD_OP_DIV) begin
          remainder_d = div_change_sign ? {2'b00, sub_res} : remainder_q;
        end else begin
          remainder_d = rem_change_sign ? {2'b00, sub_res} : remainder_q;
        end
        state_d = FINISH;
      end

      FINISH: begin
        valid_o = 1'b1;
        hold    = ~ready_i;
        state_d = IDLE;
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  assign step_en = en_i & ~hold;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= IDLE;
      numerator_q   <= '0;
      denominator_q <= '0;
      quotient_q    <= '0;
      remainder_q   <= '0;
      cnt_q         <= '0;
    end else if (step_en) begin
      state_q       <= state_d;
      numerator_q   <= numerator_d;
      denominator_q <= denominator_d;
      quotient_q    <= quotient_d;
      remainder_q   <= remainder_d;
      cnt_q         <= cnt_d;
    end
  end

  // Quotient or remainder sits in the remainder register at FINISH
  assign result_o = remainder_q[W-1:0];

endmodule

`default_nettype wire

//--- rtl/md_multdiv.sv
// ##########################################################################
// Top level of the RV32M multiply/divide unit
// Joins multiplier and divider, merges valid and result
// ##########################################################################

`default_nettype none

module md_multdiv (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           mult_en_i,
  input  logic                           div_en_i,
  input  logic                           ready_i,
  input  md_pkg::md_op_e                 operator_i,
  input  logic [1:0]                     signed_mode_i,
  input  logic [md_pkg::MD_WIDTH-1:0]    op_a_i,
  input  logic [md_pkg::MD_WIDTH-1:0]    op_b_i,
  output logic [md_pkg::MD_WIDTH-1:0]    result_o,
  output logic                           valid_o
);

  logic [md_pkg::MD_WIDTH-1:0] mult_result;
  logic [md_pkg::MD_WIDTH-1:0] div_result;
  logic                        mult_valid;
  logic                        div_valid;

  md_mult_fast u_mult (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .en_i          (mult_en_i),
    .ready_i       (ready_i),
    .operator_i    (operator_i),
    .signed_mode_i (signed_mode_i),
    .op_a_i        (op_a_i),
    .op_b_i        (op_b_i),
    .result_o      (mult_result),
    .valid_o       (mult_valid)
  );

  md_div_long u_div (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .en_i          (div_en_i),
    .ready_i       (ready_i),
    .operator_i    (operator_i),
    .signed_mode_i (signed_mode_i),
    .op_a_i        (op_a_i),
    .op_b_i        (op_b_i),
    .result_o      (div_result),
    .valid_o       (div_valid)
  );

  // Only one unit is enabled at a time
  assign valid_o  = mult_valid | div_valid;
  assign result_o = div_valid ? div_result : mult_result;

endmodule

`default_nettype wire

//--- tests/md_multdiv_assert.sv
// ##########################################################################
// Concurrent assertions for the multiply/divide top level
// Quiet reset, result latency per operation, hold under back-pressure
// ##########################################################################

`default_nettype none

module md_multdiv_assert (
  input logic                        clk_i,
  input logic                        rst_ni,
  input logic                        mult_en_i,
  input logic                        div_en_i,
  input logic                        ready_i,
  input md_pkg::md_op_e              operator_i,
  input logic [md_pkg::MD_WIDTH-1:0] op_b_i,
  input logic [md_pkg::MD_WIDTH-1:0] result_o,
  input logic                        valid_o
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_cnt = 0;
  logic        seen_en;
  logic [5:0]  en_cnt;
  logic [5:0]  exp_cnt;

  // Enabled edges seen before the result of the current operation
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seen_en <= 1'b0;
      en_cnt  <= '0;
    end else begin
      if (mult_en_i || div_en_i) begin
        seen_en <= 1'b1;
      end
      if (valid_o && ready_i) begin
        en_cnt <= '0;
      end else if ((mult_en_i || div_en_i) && !valid_o) begin
        en_cnt <= en_cnt + 1'b1;
      end
    end
  end

  // Valid is sampled high at edge 3 (MULL), 4 (MULH), 37 (DIV/REM) or 2 (zero divisor)
  always_comb begin
    if (div_en_i) begin
      exp_cnt = (op_b_i == '0) ? 6'd1 : 6'd36;
    end else begin
      exp_cnt = (operator_i == md_pkg::MD_OP_MULL) ? 6'd2 : 6'd3;
    end
  end

  a_reset_quiet: assert property (@(posedge clk_i) !rst_ni |-> !valid_o)
    else begin
      $error("valid_o is high while reset is asserted");
      fail_cnt++;
    end

  a_no_early_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !seen_en |-> !valid_o)
    else begin
      $error("valid_o went high before any enable was raised");
      fail_cnt++;
    end

  a_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o |-> en_cnt == exp_cnt)
    else begin
      $error("valid_o came after %0d enabled edges instead of %0d", en_cnt, exp_cnt);
      fail_cnt++;
    end

  a_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o && !ready_i |=> valid_o && $stable(result_o))
    else begin
      $error("Result was not held while ready_i was low");
      fail_cnt++;
    end

endmodule

bind md_multdiv md_multdiv_assert u_assert (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .mult_en_i  (mult_en_i),
  .div_en_i   (div_en_i),
  .ready_i    (ready_i),
  .operator_i (operator_i),
  .op_b_i     (op_b_i),
  .result_o   (result_o),
  .valid_o    (valid_o)
);

`default_nettype wire

//--- tests/tb_md_multdiv.sv
// ##########################################################################
// Testbench for the RV32M multiply/divide unit
// Directed and random MUL/MULH/DIV/REM, back-pressure, watchdog, summary
// ##########################################################################

`default_nettype none

module tb_md_multdiv;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned W          = md_pkg::MD_WIDTH;
  localparam int unsigned CLK_PERIOD = 4;
  localparam int unsigned SEED       = 32'ha9db7bac;
  localparam int unsigned N_RAND     = 50;
  localparam int unsigned N_MULH     = 10;
  localparam int unsigned N_BP       = 8;
  // Multiplies need up to 5 cycles, divisions 40, stalls add up to 8 more
  localparam int unsigned MUL_OPS = 36 + N_RAND + 4 * (36 + N_MULH);
  localparam int unsigned DIV_OPS = 2 + N_RAND + 12;
  localparam int unsigned TIMEOUT_CYCLES = MUL_OPS * 5 + DIV_OPS * 40 + N_BP * 48 + 200;

  logic           clk_i;
  logic           rst_ni;
  logic           mult_en_i;
  logic           div_en_i;
  logic           ready_i;
  md_pkg::md_op_e operator_i;
  logic [1:0]     signed_mode_i;
  logic [W-1:0]   op_a_i;
  logic [W-1:0]   op_b_i;
  logic [W-1:0]   result_o;
  logic           valid_o;

  int unsigned checks;
  int unsigned errors;
  int unsigned tests;

  logic [W-1:0] corners [6] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000,
                                32'h7fff_ffff, 32'h0001_8000};

  md_multdiv dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Reference result from the RV32M rules
  function automatic logic [W-1:0] expected_result(input md_pkg::md_op_e op,
      input logic [1:0] mode, input logic [W-1:0] a, input logic [W-1:0] b);
    logic [2*W-1:0] wa;
    logic [2*W-1:0] wb;
    logic [2*W-1:0] prod;
    logic           sdiv;
    wa   = {{W{mode[0] & a[W-1]}}, a};
    wb   = {{W{mode[1] & b[W-1]}}, b};
    prod = wa * wb;
    sdiv = (mode == 2'b11);
    case (op)
      md_pkg::MD_OP_MULL: return prod[W-1:0];
      md_pkg::MD_OP_MULH: return prod[2*W-1:W];
      default: begin
        if (b == '0)
          return (op == md_pkg::MD_OP_DIV) ? '1 : a;
        // Signed overflow
        if (sdiv && a == {1'b1, {(W-1){1'b0}}} && b == '1)
          return (op == md_pkg::MD_OP_DIV) ? a : '0;
        if (sdiv)
          return (op == md_pkg::MD_OP_DIV) ? $signed(a) / $signed(b) : $signed(a) % $signed(b);
        return (op == md_pkg::MD_OP_DIV) ? a / b : a % b;
      end
    endcase
  endfunction

  // Starts on a rising edge, returns on the handshake edge
  task automatic run_op(input md_pkg::md_op_e op, input logic [1:0] mode,
      input logic [W-1:0] a, input logic [W-1:0] b, input int unsigned stall);
    logic [W-1:0] exp;
    exp = expected_result(op, mode, a, b);
    operator_i    <= op;
    signed_mode_i <= mode;
    op_a_i        <= a;
    op_b_i        <= b;
    mult_en_i     <= (op == md_pkg::MD_OP_MULL) || (op == md_pkg::MD_OP_MULH);
    div_en_i      <= (op == md_pkg::MD_OP_DIV) || (op == md_pkg::MD_OP_REM);
    ready_i       <= (stall == 0);
    do begin
      @(negedge clk_i);
    end while (!valid_o);
    if (stall > 0) begin
      repeat (stall) @(posedge clk_i);
      ready_i <= 1'b1;
      @(negedge clk_i);
    end
    checks++;
    if (!valid_o || result_o !== exp) begin
      errors++;
      $display("Error: result_o %s mode %b a %h b %h expected %h got %h (valid_o %b)",
               op.name(), mode, a, b, exp, result_o, valid_o);
    end
    @(posedge clk_i);
  endtask

  task automatic report_test(input string name, input int unsigned err_start);
    tests++;
    $display("Test %-12s done, %0d checks so far, %0d errors", name, checks,
             errors - err_start);
  endtask

  initial begin : stimulus
    int unsigned    err_start;
    int unsigned    asrt_fails;
    logic [W-1:0]   b;
    md_pkg::md_op_e op;
    void'($urandom(SEED));
    checks        = 0;
    errors        = 0;
    tests         = 0;
    rst_ni        <= 1'b0;
    mult_en_i     <= 1'b0;
    div_en_i      <= 1'b0;
    ready_i       <= 1'b1;
    operator_i    <= md_pkg::MD_OP_MULL;
    signed_mode_i <= 2'b00;
    op_a_i        <= '0;
    op_b_i        <= '0;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;

    err_start = errors;
    repeat (4) begin
      @(negedge clk_i);
      checks++;
      if (valid_o !== 1'b0) begin
        errors++;
        $display("Error: valid_o expected 0 got %h with no enable", valid_o);
      end
    end
    @(posedge clk_i);
    report_test("reset", err_start);

    err_start = errors;
    foreach (corners[i]) begin
      foreach (corners[j]) begin
        run_op(md_pkg::MD_OP_MULL, 2'(i + j), corners[i], corners[j], 0);
      end
    end
    for (int n = 0; n < N_RAND; n++) begin
      run_op(md_pkg::MD_OP_MULL, 2'(n), $urandom(), $urandom(), 0);
    end
    report_test("mull", err_start);

    err_start = errors;
    for (int m = 0; m < 4; m++) begin
      foreach (corners[i]) begin
        foreach (corners[j]) begin
          run_op(md_pkg::MD_OP_MULH, 2'(m), corners[i], corners[j], 0);
        end
      end
      repeat (N_MULH) run_op(md_pkg::MD_OP_MULH, 2'(m), $urandom(), $urandom(), 0);
    end
    report_test("mulh", err_start);

    err_start = errors;
    run_op(md_pkg::MD_OP_DIV, 2'b11, 32'h8000_0000, '1, 0);
    run_op(md_pkg::MD_OP_REM, 2'b11, 32'h8000_0000, '1, 0);
    for (int n = 0; n < N_RAND; n++) begin
      op = n[0] ? md_pkg::MD_OP_REM : md_pkg::MD_OP_DIV;
      // Spread divisor size so quotients cover many bit positions
      b  = $urandom() >> ($urandom() % 32);
      run_op(op, n[1] ? 2'b11 : 2'b00, $urandom(), b, 0);
    end
    report_test("div_rem", err_start);

    err_start = errors;
    foreach (corners[i]) begin
      run_op(md_pkg::MD_OP_DIV, i[0] ? 2'b11 : 2'b00, corners[i], '0, 0);
      run_op(md_pkg::MD_OP_REM, i[0] ? 2'b11 : 2'b00, corners[i], '0, 0);
    end
    report_test("div_zero", err_start);

    err_start = errors;
    for (int n = 0; n < N_BP; n++) begin
      op = md_pkg::md_op_e'(2'(n));
      run_op(op, 2'b11, $urandom(), $urandom(), 1 + $urandom() % 8);
    end
    mult_en_i <= 1'b0;
    div_en_i  <= 1'b0;
    repeat (2) @(posedge clk_i);
    report_test("backpressure", err_start);

    asrt_fails = dut.u_assert.fail_cnt;
    $display("Tests %0d, checks %0d, result errors %0d, assertion failures %0d",
             tests, checks, errors, asrt_fails);
    if (errors == 0 && asrt_fails == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("Run timed out after %0d cycles without finishing all tests", TIMEOUT_CYCLES);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
rtl/md_pkg.sv
rtl/md_mult_fast.sv
rtl/md_div_long.sv
rtl/md_multdiv.sv
tests/md_multdiv_assert.sv
tests/tb_md_multdiv.sv

//--- Bender.yml
package:
  name: md_multdiv

sources:
  # RTL in compile order
  - files:
      - rtl/md_pkg.sv
      - rtl/md_mult_fast.sv
      - rtl/md_div_long.sv
      - rtl/md_multdiv.sv

  # Testbench and bound assertions
  - target: test
    files:
      - tests/md_multdiv_assert.sv
      - tests/tb_md_multdiv.sv
